// ==== Makefile ====
# Verilator build and run for the uranus memory side

VERILATOR ?= verilator
TOP       ?= uranus_mem_tb
FILELIST  ?= uranus_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Simulation passed

.PHONY: sim clean

# the run only counts as passed when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/axi_bridge.sv ====
`timescale 1ns/1ns

`include "uranus_macros.svh"

module axi_bridge
    import mem_bus_pkg::*;
    import axi_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,

    input  logic        not_empty,
    input  tagged_req_t head,
    output logic        pop,

    output axi_ar_t     ar,
    output logic        arvalid,
    input  logic        arready,
    input  axi_r_t      r,
    input  logic        rvalid,
    output logic        rready,
    output axi_aw_t     aw,
    output logic        awvalid,
    input  logic        awready,
    output axi_w_t      w,
    output logic        wvalid,
    input  logic        wready,
    input  axi_b_t      b,
    input  logic        bvalid,
    output logic        bready,

    output logic        inst_resp_stb,
    output mem_resp_t   inst_resp,
    output logic        data_resp_stb,
    output mem_resp_t   data_resp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RWAIT,
        ST_WWAIT,
        ST_RESP
    } state_e;

    state_e      state;
    state_e      state_nxt;
    tagged_req_t cur;
    mem_resp_t   resp_q;
    vaddr_u      vaddr;
    vaddr_u      paddr;
    axi_ax_t     ax;
    logic [3:0]  strb;
    logic        aw_done;
    logic        w_done;
    logic        aw_fire;
    logic        w_fire;

    always_comb begin
        vaddr.raw = cur.req.addr;
        paddr     = vaddr;
        // kseg0 and kseg1 are unmapped windows onto low physical memory
        if (vaddr.split.seg == 3'd4 || vaddr.split.seg == 3'd5) begin
            paddr.split.seg = 3'd0;
        end
    end

    always_comb begin
        case (cur.req.size)
            MEM_SIZE_BYTE: strb = 4'b0001 << paddr.raw[1:0];
            MEM_SIZE_HALF: strb = paddr.raw[1] ? 4'b1100 : 4'b0011;
            default:       strb = 4'b1111;
        endcase
    end

    always_comb begin
        ax.id    = (cur.src == MEM_SRC_DATA) ? `AXI_ID_DATA : `AXI_ID_INST;
        ax.addr  = paddr.raw;
        ax.len   = 8'd0;
        ax.size  = {1'b0, cur.req.size};
        ax.burst = AXI_BURST_INCR;
        ax.lock  = 2'b00;
        ax.cache = 4'b0000;
        ax.prot  = 3'b000;
    end

    assign ar = ax;
    assign aw = ax;
    assign w  = '{id: ax.id, data: cur.req.wdata, strb: strb, last: 1'b1};

    assign pop     = (state == ST_IDLE) && not_empty;
    assign arvalid = (state == ST_ADDR) && !cur.req.wr;
    assign awvalid = (state == ST_ADDR) && cur.req.wr && !aw_done;
    assign wvalid  = (state == ST_ADDR) && cur.req.wr && !w_done;
    assign rready  = (state == ST_RWAIT);
    assign bready  = (state == ST_WWAIT);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (not_empty) begin
                    state_nxt = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (!cur.req.wr) begin
                    if (arready) begin
                        state_nxt = ST_RWAIT;
                    end
                end else if ((aw_done || aw_fire) && (w_done || w_fire)) begin
                    state_nxt = ST_WWAIT;
                end
            end
            ST_RWAIT: begin
                if (rvalid) begin
                    state_nxt = ST_RESP;
                end
            end
            ST_WWAIT: begin
                if (bvalid) begin
                    state_nxt = ST_RESP;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // aw and w may be accepted in either order
            aw_done <= (state == ST_ADDR) && (state_nxt == ST_ADDR) && (aw_done || aw_fire);
            w_done  <= (state == ST_ADDR) && (state_nxt == ST_ADDR) && (w_done || w_fire);
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            cur <= head;
        end
        if (rvalid && rready) begin
            resp_q.rdata <= r.data;
            resp_q.err   <= (r.resp != AXI_RESP_OKAY);
        end else if (bvalid && bready) begin
            resp_q.rdata <= '0;
            resp_q.err   <= (b.resp != AXI_RESP_OKAY);
        end
    end

    assign inst_resp_stb = (state == ST_RESP) && (cur.src == MEM_SRC_INST);
    assign data_resp_stb = (state == ST_RESP) && (cur.src == MEM_SRC_DATA);
    assign inst_resp     = resp_q;
    assign data_resp     = resp_q;

endmodule

// ==== logic/axi_pkg.sv ====
package axi_pkg;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // read and write address channels share one layout
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
        axi_burst_e  burst;
        logic [1:0]  lock;
        logic [3:0]  cache;
        logic [2:0]  prot;
    } axi_ax_t;

    typedef axi_ax_t axi_ar_t;
    typedef axi_ax_t axi_aw_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [3:0] id;
        axi_resp_e  resp;
    } axi_b_t;

endpackage

// ==== logic/mem_bus_pkg.sv ====
package mem_bus_pkg;

    typedef enum logic [1:0] {
        MEM_SIZE_BYTE = 2'd0,
        MEM_SIZE_HALF = 2'd1,
        MEM_SIZE_WORD = 2'd2
    } mem_size_e;

    typedef enum logic {
        MEM_SRC_INST = 1'b0,
        MEM_SRC_DATA = 1'b1
    } mem_src_e;

    // wdata is already lane aligned by the client
    typedef struct packed {
        logic        wr;
        mem_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        mem_src_e src;
        mem_req_t req;
    } tagged_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } mem_resp_t;

    // one address word, read whole or as mips segment plus offset
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [2:0]  seg;
            logic [28:0] offset;
        } split;
    } vaddr_u;

endpackage

// ==== logic/req_arbiter.sv ====
`timescale 1ns/1ns

module req_arbiter
    import mem_bus_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,

    input  logic        inst_req_stb,
    input  mem_req_t    inst_req,
    input  logic        data_req_stb,
    input  mem_req_t    data_req,

    output logic        push,
    output tagged_req_t push_req
);

    logic     pend_vld;
    mem_req_t pend_req;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            push     <= 1'b0;
            pend_vld <= 1'b0;
        end else begin
            push <= data_req_stb | inst_req_stb | pend_vld;
            if (data_req_stb) begin
                // inst lost the tie and waits one cycle in the pending slot
                pend_vld <= inst_req_stb;
            end else if (pend_vld) begin
                pend_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (data_req_stb) begin
            push_req.src <= MEM_SRC_DATA;
            push_req.req <= data_req;
            if (inst_req_stb) begin
                pend_req <= inst_req;
            end
        end else if (pend_vld) begin
            push_req.src <= MEM_SRC_INST;
            push_req.req <= pend_req;
        end else if (inst_req_stb) begin
            push_req.src <= MEM_SRC_INST;
            push_req.req <= inst_req;
        end
    end

endmodule

// ==== logic/req_queue.sv ====
`timescale 1ns/1ns

`include "uranus_macros.svh"

module req_queue
    import mem_bus_pkg::*;
(
    input  logic        aclk,
    input  logic        rst_n,

    input  logic        push,
    input  tagged_req_t push_req,

    input  logic        pop,
    output logic        not_empty,
    output tagged_req_t head
);

    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    tagged_req_t        mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full;
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

endmodule

// ==== logic/uranus_macros.svh ====
`ifndef URANUS_MACROS_SVH
`define URANUS_MACROS_SVH

// at least 2 request queue entries so both clients fit
`define QUEUE_DEPTH 2

// axi transaction ids per client
`define AXI_ID_INST 4'd0
`define AXI_ID_DATA 4'd1

`endif

// ==== logic/uranus_mem.sv ====
`timescale 1ns/1ns

module uranus_mem
    import mem_bus_pkg::*;
    import axi_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,

    input  logic      inst_req_stb,
    input  mem_req_t  inst_req,
    output logic      inst_resp_stb,
    output mem_resp_t inst_resp,

    input  logic      data_req_stb,
    input  mem_req_t  data_req,
    output logic      data_resp_stb,
    output mem_resp_t data_resp,

    output axi_ar_t   ar,
    output logic      arvalid,
    input  logic      arready,
    input  axi_r_t    r,
    input  logic      rvalid,
    output logic      rready,
    output axi_aw_t   aw,
    output logic      awvalid,
    input  logic      awready,
    output axi_w_t    w,
    output logic      wvalid,
    input  logic      wready,
    input  axi_b_t    b,
    input  logic      bvalid,
    output logic      bready
);

    logic        push;
    tagged_req_t push_req;
    logic        not_empty;
    tagged_req_t head;
    logic        pop;

    req_arbiter u_arbiter (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .inst_req_stb (inst_req_stb),
        .inst_req     (inst_req),
        .data_req_stb (data_req_stb),
        .data_req     (data_req),
        .push         (push),
        .push_req     (push_req)
    );

    req_queue u_queue (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .push      (push),
        .push_req  (push_req),
        .pop       (pop),
        .not_empty (not_empty),
        .head      (head)
    );

    axi_bridge u_bridge (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .not_empty     (not_empty),
        .head          (head),
        .pop           (pop),
        .ar            (ar),
        .arvalid       (arvalid),
        .arready       (arready),
        .r             (r),
        .rvalid        (rvalid),
        .rready        (rready),
        .aw            (aw),
        .awvalid       (awvalid),
        .awready       (awready),
        .w             (w),
        .wvalid        (wvalid),
        .wready        (wready),
        .b             (b),
        .bvalid        (bvalid),
        .bready        (bready),
        .inst_resp_stb (inst_resp_stb),
        .inst_resp     (inst_resp),
        .data_resp_stb (data_resp_stb),
        .data_resp     (data_resp)
    );

endmodule

// ==== testbench/uranus_mem_assert.sv ====
`timescale 1ns/1ns

`include "uranus_macros.svh"

module uranus_mem_assert (
    input logic aclk,
    input logic rst_n,
    input logic arvalid,
    input logic arready,
    input logic rvalid,
    input logic rready,
    input logic awvalid,
    input logic awready,
    input logic wvalid,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic push,
    input logic pop,
    input logic inst_resp_stb,
    input logic data_resp_stb
);

    localparam int DEPTH = `QUEUE_DEPTH;

    int occupancy;
    int fails;

    // queue fill level rebuilt from push and pop
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(push && occupancy < DEPTH) - int'(pop && occupancy > 0);
        end
    end

    property held_until_ready(logic valid, logic ready);
        @(posedge aclk) disable iff (!rst_n) valid && !ready |=> valid;
    endproperty

    property single_cycle(logic stb);
        @(posedge aclk) disable iff (!rst_n) stb |=> !stb;
    endproperty

    ar_hold: assert property (held_until_ready(arvalid, arready))
        else begin
            fails++;
            $error("arvalid dropped before arready");
        end
    r_hold: assert property (held_until_ready(rvalid, rready))
        else begin
            fails++;
            $error("rvalid dropped before rready");
        end
    aw_hold: assert property (held_until_ready(awvalid, awready))
        else begin
            fails++;
            $error("awvalid dropped before awready");
        end
    w_hold: assert property (held_until_ready(wvalid, wready))
        else begin
            fails++;
            $error("wvalid dropped before wready");
        end
    b_hold: assert property (held_until_ready(bvalid, bready))
        else begin
            fails++;
            $error("bvalid dropped before bready");
        end

    no_push_full: assert property (@(posedge aclk) disable iff (!rst_n) push |-> occupancy < DEPTH)
        else begin
            fails++;
            $error("push into a full request queue");
        end

    resp_exclusive: assert property (@(posedge aclk) disable iff (!rst_n)
                                     !(inst_resp_stb && data_resp_stb))
        else begin
            fails++;
            $error("both response strobes high together");
        end

    inst_pulse: assert property (single_cycle(inst_resp_stb))
        else begin
            fails++;
            $error("inst response strobe longer than one cycle");
        end
    data_pulse: assert property (single_cycle(data_resp_stb))
        else begin
            fails++;
            $error("data response strobe longer than one cycle");
        end

endmodule

bind uranus_mem uranus_mem_assert u_assert (.*);

// ==== testbench/uranus_mem_tb.sv ====
`timescale 1ns/1ns

`include "uranus_macros.svh"

module uranus_mem_tb
    import mem_bus_pkg::*;
    import axi_pkg::*;
();

    localparam logic [31:0] SEED       = 32'd83;
    localparam int          N_REQ      = 69;
    localparam int          RESP_LIMIT = 100;
    localparam logic [31:0] ERR_BASE   = 32'h1F00_0000;

    logic        aclk;
    logic        rst_n;
    logic        inst_req_stb;
    mem_req_t    inst_req;
    logic        inst_resp_stb;
    mem_resp_t   inst_resp;
    logic        data_req_stb;
    mem_req_t    data_req;
    logic        data_resp_stb;
    mem_resp_t   data_resp;
    axi_ar_t     ar;
    logic        arvalid;
    logic        arready;
    axi_r_t      r;
    logic        rvalid;
    logic        rready;
    axi_aw_t     aw;
    logic        awvalid;
    logic        awready;
    axi_w_t      w;
    logic        wvalid;
    logic        wready;
    axi_b_t      b;
    logic        bvalid;
    logic        bready;

    logic [31:0] slave_mem [1024];
    logic [31:0] ref_mem [1024];
    axi_ar_t     ar_log [$];
    axi_aw_t     aw_log [$];
    axi_w_t      w_log [$];
    logic [31:0] stim_state;
    int          errors;
    int          inst_reqs;
    int          data_reqs;
    int          inst_resps;
    int          data_resps;

    uranus_mem dut0 (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return (32'(i) * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;
    endfunction

    function automatic logic [31:0] to_phys(input logic [31:0] va);
        // 0x8000_0000 up to 0xbfff_ffff is an unmapped window on low memory
        if (va >= 32'h8000_0000 && va <= 32'hBFFF_FFFF) begin
            return va & 32'h1FFF_FFFF;
        end
        return va;
    endfunction

    function automatic logic [3:0] lane_mask(input mem_size_e size, input logic [1:0] lo);
        logic [3:0] mask;
        for (int i = 0; i < 4; i++) begin
            case (size)
                MEM_SIZE_BYTE: mask[i] = (i == int'(lo));
                MEM_SIZE_HALF: mask[i] = ((i / 2) == int'(lo[1]));
                default:       mask[i] = 1'b1;
            endcase
        end
        return mask;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = wd[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // axi slave memory that settles every handshake at the falling edge
    initial begin : axi_slave
        logic [31:0] dly_state;
        logic        rd_pend;
        logic        aw_got;
        logic        w_got;
        logic        r_commit;
        logic        b_commit;
        logic        err;
        int          ar_dly;
        int          aw_dly;
        int          w_dly;
        int          rsp_dly;
        axi_ar_t     ar_q;
        axi_aw_t     aw_q;
        axi_w_t      w_q;
        for (int i = 0; i < 1024; i++) begin
            slave_mem[i] = fill_word(i);
        end
        dly_state = xorshift(SEED);
        {rd_pend, aw_got, w_got, r_commit, b_commit} = '0;
        {ar_dly, aw_dly, w_dly, rsp_dly} = '0;
        {arready, awready, wready, rvalid, bvalid} = '0;
        r = '0;
        b = '0;
        forever begin
            @(negedge aclk);
            if (r_commit) begin
                rvalid = 1'b0;
            end
            if (b_commit) begin
                bvalid = 1'b0;
            end
            // responses only follow handshakes of earlier cycles
            if (rd_pend && !rvalid) begin
                if (rsp_dly == 0) begin
                    err = ar_q.addr >= ERR_BASE;
                    r = '{id: ar_q.id, data: slave_mem[ar_q.addr[11:2]],
                          resp: err ? AXI_RESP_SLVERR : AXI_RESP_OKAY, last: 1'b1};
                    rvalid  = 1'b1;
                    rd_pend = 1'b0;
                end else begin
                    rsp_dly--;
                end
            end
            if (aw_got && w_got && !bvalid) begin
                if (rsp_dly == 0) begin
                    err = aw_q.addr >= ERR_BASE;
                    if (!err) begin
                        slave_mem[aw_q.addr[11:2]] =
                            merge_lanes(slave_mem[aw_q.addr[11:2]], w_q.data, w_q.strb);
                    end
                    b = '{id: aw_q.id, resp: err ? AXI_RESP_SLVERR : AXI_RESP_OKAY};
                    bvalid = 1'b1;
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                end else begin
                    rsp_dly--;
                end
            end
            arready = arvalid && ar_dly == 0;
            awready = awvalid && aw_dly == 0;
            wready  = wvalid && w_dly == 0;
            if (arvalid && !arready) begin
                ar_dly--;
            end
            if (awvalid && !awready) begin
                aw_dly--;
            end
            if (wvalid && !wready) begin
                w_dly--;
            end
            if (arvalid && arready) begin
                ar_q = ar;
                ar_log.push_back(ar);
                rd_pend = 1'b1;
                dly_state = xorshift(dly_state);
                ar_dly  = int'(dly_state[1:0]);
                rsp_dly = int'(dly_state[3:2]);
            end
            if (awvalid && awready) begin
                aw_q = aw;
                aw_log.push_back(aw);
                aw_got = 1'b1;
                dly_state = xorshift(dly_state);
                aw_dly  = int'(dly_state[1:0]);
                rsp_dly = int'(dly_state[3:2]);
            end
            if (wvalid && wready) begin
                w_q = w;
                w_log.push_back(w);
                w_got = 1'b1;
                dly_state = xorshift(dly_state);
                w_dly = int'(dly_state[1:0]);
            end
            r_commit = rvalid && rready;
            b_commit = bvalid && bready;
        end
    end

    initial begin
        inst_resps = 0;
        data_resps = 0;
        forever begin
            @(negedge aclk);
            if (inst_resp_stb) begin
                inst_resps++;
            end
            if (data_resp_stb) begin
                data_resps++;
            end
        end
    end

    task automatic client_access(input mem_src_e src, input logic wr, input mem_size_e size,
                                 input logic [31:0] addr, input logic [31:0] wdata);
        mem_req_t    req;
        mem_resp_t   resp;
        logic [31:0] pa;
        logic [31:0] exp_data;
        logic        exp_err;
        logic        got;
        int          waited;
        string       who;
        req = '{wr: wr, size: size, addr: addr, wdata: wdata};
        who = (src == MEM_SRC_DATA) ? "data" : "inst";
        pa = to_phys(addr);
        exp_err = pa >= ERR_BASE;
        exp_data = ref_mem[pa[11:2]];
        if (wr && !exp_err) begin
            ref_mem[pa[11:2]] = merge_lanes(exp_data, wdata, lane_mask(size, pa[1:0]));
        end
        @(negedge aclk);
        if (src == MEM_SRC_DATA) begin
            data_req_stb = 1'b1;
            data_req = req;
            data_reqs++;
        end else begin
            inst_req_stb = 1'b1;
            inst_req = req;
            inst_reqs++;
        end
        @(negedge aclk);
        if (src == MEM_SRC_DATA) begin
            data_req_stb = 1'b0;
        end else begin
            inst_req_stb = 1'b0;
        end
        got = 1'b0;
        waited = 0;
        while (!got && waited < RESP_LIMIT) begin
            if (src == MEM_SRC_DATA ? data_resp_stb : inst_resp_stb) begin
                got = 1'b1;
                resp = (src == MEM_SRC_DATA) ? data_resp : inst_resp;
            end else begin
                @(negedge aclk);
                waited++;
            end
        end
        if (!got) begin
            errors++;
            $display("%0t: %s client got no response for address %h", $time, who, addr);
        end else begin
            expect_eq({who, "_resp.err"}, 32'(resp.err), 32'(exp_err));
            if (!wr && !exp_err) begin
                expect_eq({who, "_resp.rdata"}, resp.rdata, exp_data);
            end
        end
    endtask

    task automatic inst_read_kseg0;
        ar_log.delete();
        client_access(MEM_SRC_INST, 1'b0, MEM_SIZE_WORD, 32'h8000_0040, '0);
        if (ar_log.size() != 1) begin
            errors++;
            $display("%0t: kseg0 read gave %0d AR transfers instead of one", $time, ar_log.size());
        end else begin
            expect_eq("araddr", ar_log[0].addr, 32'h0000_0040);
            expect_eq("arid", 32'(ar_log[0].id), 32'(`AXI_ID_INST));
            expect_eq("arsize", 32'(ar_log[0].size), 32'd2);
            expect_eq("arlen", 32'(ar_log[0].len), 32'd0);
            expect_eq("arburst", 32'(ar_log[0].burst), 32'd1);
        end
    endtask

    task automatic data_write_kseg1;
        aw_log.delete();
        w_log.delete();
        client_access(MEM_SRC_DATA, 1'b1, MEM_SIZE_BYTE, 32'hA000_0101, 32'h0000_AB00);
        client_access(MEM_SRC_DATA, 1'b1, MEM_SIZE_HALF, 32'hA000_0102, 32'hCDEF_0000);
        if (aw_log.size() != 2 || w_log.size() != 2) begin
            errors++;
            $display("%0t: two kseg1 writes did not give two AW and two W transfers", $time);
        end else begin
            expect_eq("awaddr", aw_log[0].addr, 32'h0000_0101);
            expect_eq("wstrb", 32'(w_log[0].strb), 32'h2);
            expect_eq("awaddr", aw_log[1].addr, 32'h0000_0102);
            expect_eq("wstrb", 32'(w_log[1].strb), 32'hC);
            expect_eq("awid", 32'(aw_log[0].id), 32'(`AXI_ID_DATA));
            expect_eq("awsize", 32'(aw_log[0].size), 32'd0);
            expect_eq("awsize", 32'(aw_log[1].size), 32'd1);
            expect_eq("wlast", 32'(w_log[0].last), 32'd1);
        end
        client_access(MEM_SRC_DATA, 1'b0, MEM_SIZE_WORD, 32'hA000_0100, '0);
    endtask

    task automatic same_cycle_strobes;
        ar_log.delete();
        fork
            client_access(MEM_SRC_DATA, 1'b0, MEM_SIZE_WORD, 32'h8000_0200, '0);
            client_access(MEM_SRC_INST, 1'b0, MEM_SIZE_WORD, 32'h8000_0080, '0);
        join
        if (ar_log.size() != 2) begin
            errors++;
            $display("%0t: same cycle reads gave %0d AR transfers", $time, ar_log.size());
        end else begin
            expect_eq("first arid", 32'(ar_log[0].id), 32'(`AXI_ID_DATA));
            expect_eq("second arid", 32'(ar_log[1].id), 32'(`AXI_ID_INST));
        end
    endtask

    task automatic slave_error;
        client_access(MEM_SRC_INST, 1'b0, MEM_SIZE_WORD, 32'hBF00_0010, '0);
        client_access(MEM_SRC_DATA, 1'b1, MEM_SIZE_WORD, 32'hBF00_0014, 32'h1234_5678);
        expect_eq("slave_mem[5]", slave_mem[5], ref_mem[5]);
        client_access(MEM_SRC_DATA, 1'b0, MEM_SIZE_WORD, 32'h8000_0014, '0);
    endtask

    task automatic random_mix;
        mem_req_t    inst_ops [$];
        mem_req_t    data_ops [$];
        mem_req_t    op;
        logic [31:0] rnd;
        logic [31:0] va;
        logic [1:0]  lo;
        mem_size_e   size;
        for (int i = 0; i < 60; i++) begin
            stim_state = xorshift(stim_state);
            rnd = stim_state;
            size = (rnd[3:2] == 2'd3) ? MEM_SIZE_WORD : mem_size_e'(rnd[3:2]);
            case (size)
                MEM_SIZE_BYTE: lo = rnd[12:11];
                MEM_SIZE_HALF: lo = {rnd[12], 1'b0};
                default:       lo = 2'b00;
            endcase
            // inst and data keep to their own 512 byte regions
            va = {22'd0, rnd[0], rnd[10:4], lo};
            if (rnd[14]) begin
                va[31:29] = rnd[13] ? 3'd5 : 3'd4;
            end
            stim_state = xorshift(stim_state);
            op = '{wr: rnd[1], size: size, addr: va, wdata: stim_state};
            if (rnd[0]) begin
                data_ops.push_back(op);
            end else begin
                inst_ops.push_back(op);
            end
        end
        fork
            for (int i = 0; i < inst_ops.size(); i++) begin
                client_access(MEM_SRC_INST, inst_ops[i].wr, inst_ops[i].size,
                              inst_ops[i].addr, inst_ops[i].wdata);
            end
            for (int j = 0; j < data_ops.size(); j++) begin
                client_access(MEM_SRC_DATA, data_ops[j].wr, data_ops[j].size,
                              data_ops[j].addr, data_ops[j].wdata);
            end
        join
    endtask

    initial begin
        repeat (N_REQ * 200) @(posedge aclk);
        $display("%0t: watchdog expired before the tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        errors = 0;
        inst_reqs = 0;
        data_reqs = 0;
        stim_state = SEED;
        rst_n = 1'b0;
        inst_req_stb = 1'b0;
        inst_req = '0;
        data_req_stb = 1'b0;
        data_req = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        inst_read_kseg0();
        data_write_kseg1();
        same_cycle_strobes();
        slave_error();
        random_mix();
        // late or extra response strobes show up in the counts
        repeat (8) @(negedge aclk);
        if (inst_resps != inst_reqs || data_resps != data_reqs) begin
            errors++;
            $display("%0t: response count does not match request count", $time);
        end
        errors += dut0.u_assert.fails;
        $display("errors %0d, inst requests %0d responses %0d, data requests %0d responses %0d",
                 errors, inst_reqs, inst_resps, data_reqs, data_resps);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== uranus_mem.f ====
+incdir+logic
logic/mem_bus_pkg.sv
logic/axi_pkg.sv
logic/req_arbiter.sv
logic/req_queue.sv
logic/axi_bridge.sv
logic/uranus_mem.sv
testbench/uranus_mem_assert.sv
testbench/uranus_mem_tb.sv
